/* Makefile */
# Verilator build and run of the raster core testbench
TOP = raster_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* flist.f */
source/raster_pkg.sv
source/modeline_regs.sv
source/raster_timing.sv
source/pixel_fetch.sv
source/video_out.sv
source/raster_core_top.sv
tb/raster_core_chk.sv
tb/raster_core_tb.sv

/* source/modeline_regs.sv */
/* new mode takes effect the cycle after frame_end, a load while busy replaces it
   field values are not range checked, ce_div below 2 is not supported */
`timescale 1ns/100ps

module modeline_regs (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                mode_load,   // one cycle strobe
	input  logic                frame_end,   // from raster, last pixel of frame
	input  raster_pkg::coord_t  mode_h,
	input  raster_pkg::porch_t  mode_hfp,
	input  raster_pkg::porch_t  mode_hs,
	input  raster_pkg::porch_t  mode_hbp,
	input  raster_pkg::coord_t  mode_v,
	input  raster_pkg::porch_t  mode_vfp,
	input  raster_pkg::porch_t  mode_vs,
	input  raster_pkg::porch_t  mode_vbp,
	input  raster_pkg::ce_div_t mode_ce_div,
	output raster_pkg::coord_t  act_h,
	output raster_pkg::porch_t  act_hfp,
	output raster_pkg::porch_t  act_hs,
	output raster_pkg::porch_t  act_hbp,
	output raster_pkg::coord_t  act_v,
	output raster_pkg::porch_t  act_vfp,
	output raster_pkg::porch_t  act_vs,
	output raster_pkg::porch_t  act_vbp,
	output raster_pkg::ce_div_t act_ce_div,
	output logic                mode_busy    // pending mode waiting for frame end
);
	import raster_pkg::*;

	coord_t  pend_h, pend_v;
	porch_t  pend_hfp, pend_hs, pend_hbp;
	porch_t  pend_vfp, pend_vs, pend_vbp;
	ce_div_t pend_ce_div;

	// pending set, plain capture
	always_ff @(posedge clk_sys) begin
		if (mode_load) begin
			pend_h      <= mode_h;
			pend_hfp    <= mode_hfp;
			pend_hs     <= mode_hs;
			pend_hbp    <= mode_hbp;
			pend_v      <= mode_v;
			pend_vfp    <= mode_vfp;
			pend_vs     <= mode_vs;
			pend_vbp    <= mode_vbp;
			pend_ce_div <= mode_ce_div;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			act_h      <= DEF_H;
			act_hfp    <= DEF_HFP;
			act_hs     <= DEF_HS;
			act_hbp    <= DEF_HBP;
			act_v      <= DEF_V;
			act_vfp    <= DEF_VFP;
			act_vs     <= DEF_VS;
			act_vbp    <= DEF_VBP;
			act_ce_div <= DEF_CE_DIV;
			mode_busy  <= 1'b0;
		end else begin
			if (frame_end && mode_busy) begin // swap at boundary, counters are at 0 next
				act_h      <= pend_h;
				act_hfp    <= pend_hfp;
				act_hs     <= pend_hs;
				act_hbp    <= pend_hbp;
				act_v      <= pend_v;
				act_vfp    <= pend_vfp;
				act_vs     <= pend_vs;
				act_vbp    <= pend_vbp;
				act_ce_div <= pend_ce_div;
			end
			if (mode_load)
				mode_busy <= 1'b1;   // new load wins over a coincident frame end
			else if (frame_end)
				mode_busy <= 1'b0;
		end
	end

endmodule

/* source/pixel_fetch.sv */
/* reader starts with FIFO_DEPTH credits and sends one word per credit
   word_credit pulses when the last pixel of the head word is taken */
`timescale 1ns/100ps

module pixel_fetch (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 word_valid,   // one word, costs one credit
	input  raster_pkg::fb_word_t word_data,
	input  logic                 pix_take,     // consume pix_data this cycle
	output logic                 word_credit,  // one credit back
	output logic                 pix_ready,
	output raster_pkg::pixel_t   pix_data
);
	import raster_pkg::*;

	fb_word_t             mem [FIFO_DEPTH];
	fb_word_t             head_word;
	logic [FIFO_AW-1:0]   wr_ptr, rd_ptr;
	logic [FIFO_AW:0]     count;             // words held
	logic [PIX_IDX_W-1:0] pix_idx;           // pixel within head word
	logic                 push, pop, full, empty;
	logic                 last_pix;

	assign push     = word_valid;            // credits keep this off a full buffer
	assign full     = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty    = (count == '0);
	assign last_pix = (pix_idx == PIX_IDX_W'(PIX_PER_WORD - 1));
	assign pop      = pix_take && last_pix;  // taker waits for pix_ready

	// word storage
	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= word_data;
	end

	//////////////////////////////////////////////////////////////////////
	// pointers, fill count and pixel index
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			pix_idx <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + FIFO_AW'(1); // power of two depth, wraps
			if (pop)
				rd_ptr <= rd_ptr + FIFO_AW'(1);

			case ({push, pop})
				2'b10:   count <= count + (FIFO_AW+1)'(1);
				2'b01:   count <= count - (FIFO_AW+1)'(1);
				default: count <= count;   // both or neither
			endcase

			if (pix_take) begin
				if (last_pix)
					pix_idx <= '0;
				else
					pix_idx <= pix_idx + PIX_IDX_W'(1);
			end
		end
	end

	// unpack, pixel 0 lowest
	assign head_word   = mem[rd_ptr];
	assign pix_data    = head_word[pix_idx*PIX_W +: PIX_W];
	assign pix_ready   = !empty;             // readable the cycle after push
	assign word_credit = pop;                // slot free from next cycle

endmodule

/* source/raster_core_top.sv */
/* one clock domain, synchronous active high reset
   word source must honor credits, FIFO_DEPTH of them after reset */
`timescale 1ns/100ps

module raster_core_top (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 mode_load,
	input  raster_pkg::coord_t   mode_h,
	input  raster_pkg::porch_t   mode_hfp,
	input  raster_pkg::porch_t   mode_hs,
	input  raster_pkg::porch_t   mode_hbp,
	input  raster_pkg::coord_t   mode_v,
	input  raster_pkg::porch_t   mode_vfp,
	input  raster_pkg::porch_t   mode_vs,
	input  raster_pkg::porch_t   mode_vbp,
	input  raster_pkg::ce_div_t  mode_ce_div,
	input  logic                 word_valid,
	input  raster_pkg::fb_word_t word_data,
	output logic                 mode_busy,
	output logic                 word_credit,
	output logic                 ce_out,
	output logic                 hs,
	output logic                 vs,
	output logic                 hb,
	output logic                 vb,
	output logic                 de,
	output raster_pkg::pixel_t   rgb,
	output raster_pkg::coord_t   line,          // internal count, one clock ahead of video
	output raster_pkg::frame_t   frame_count,
	output raster_pkg::stat_t    underrun_count
);
	import raster_pkg::*;

	coord_t  act_h, act_v;
	porch_t  act_hfp, act_hs, act_hbp;
	porch_t  act_vfp, act_vs, act_vbp;
	ce_div_t act_ce_div;
	logic    frame_end;
	logic    ce_pix, hsync, vsync, hblank, vblank, active;
	logic    pix_ready, pix_take;
	pixel_t  pix_data;

	//////////////////////////////////////////////////////////////////////
	// mode registers and raster
	//////////////////////////////////////////////////////////////////////

	modeline_regs u_modeline (
		.clk_sys, .rst, .mode_load, .frame_end,
		.mode_h, .mode_hfp, .mode_hs, .mode_hbp,
		.mode_v, .mode_vfp, .mode_vs, .mode_vbp, .mode_ce_div,
		.act_h, .act_hfp, .act_hs, .act_hbp,
		.act_v, .act_vfp, .act_vs, .act_vbp, .act_ce_div,
		.mode_busy
	);

	raster_timing u_timing (
		.clk_sys, .rst,
		.act_h, .act_hfp, .act_hs, .act_hbp,
		.act_v, .act_vfp, .act_vs, .act_vbp, .act_ce_div,
		.ce_pix, .hsync, .vsync, .hblank, .vblank, .active,
		.frame_end, .line, .frame_count
	);

	// pixel side, runs beside the raster
	pixel_fetch u_fetch (
		.clk_sys, .rst, .word_valid, .word_data, .pix_take,
		.word_credit, .pix_ready, .pix_data
	);

	video_out u_vout (
		.clk_sys, .rst, .ce_pix, .hsync, .vsync, .hblank, .vblank, .active,
		.pix_ready, .pix_data, .pix_take,
		.de, .hs, .vs, .hb, .vb, .ce_out, .rgb, .underrun_count
	);

endmodule

/* source/raster_pkg.sv */
/* shared widths, pixel and word types, default 256x240 modeline, buffer depth
   FIFO_DEPTH must be a power of two, PIX_PER_WORD too */
package raster_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths that carry a meaning
	//////////////////////////////////////////////////////////////////////

	localparam int PIX_W        = 24;           // rgb 8:8:8
	localparam int PIX_PER_WORD = 4;            // pixels packed in one fb word
	localparam int PIX_IDX_W    = $clog2(PIX_PER_WORD);

	localparam int FIFO_DEPTH = 8;              // words, also reader credits at reset
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	typedef logic [11:0] coord_t;               // h/v size or position
	typedef logic [7:0]  porch_t;               // porch or sync length
	typedef logic [3:0]  ce_div_t;              // sys clocks per pixel, 2..15
	typedef logic [PIX_W-1:0] pixel_t;          // r[23:16] g[15:8] b[7:0]
	typedef logic [PIX_PER_WORD*PIX_W-1:0] fb_word_t; // pixel 0 in low bits
	typedef logic [15:0] frame_t;
	typedef logic [15:0] stat_t;

	//////////////////////////////////////////////////////////////////////
	// default mode, 256x240 at divisor 15
	//////////////////////////////////////////////////////////////////////

	localparam coord_t  DEF_H      = 12'd256;
	localparam porch_t  DEF_HFP    = 8'd10;
	localparam porch_t  DEF_HS     = 8'd24;
	localparam porch_t  DEF_HBP    = 8'd41;

	localparam coord_t  DEF_V      = 12'd240;
	localparam porch_t  DEF_VFP    = 8'd2;
	localparam porch_t  DEF_VS     = 8'd3;
	localparam porch_t  DEF_VBP    = 8'd16;

	// 331 pixels x 261 lines per frame
	localparam ce_div_t DEF_CE_DIV = 4'd15;

endpackage

/* source/raster_timing.sv */
/* h total and v total (active plus porches) must fit in 12 bits
   line order is active, front porch, sync, back porch; sync is active high */
`timescale 1ns/100ps

module raster_timing (
	input  logic                clk_sys,
	input  logic                rst,
	input  raster_pkg::coord_t  act_h,
	input  raster_pkg::porch_t  act_hfp,
	input  raster_pkg::porch_t  act_hs,
	input  raster_pkg::porch_t  act_hbp,
	input  raster_pkg::coord_t  act_v,
	input  raster_pkg::porch_t  act_vfp,
	input  raster_pkg::porch_t  act_vs,
	input  raster_pkg::porch_t  act_vbp,
	input  raster_pkg::ce_div_t act_ce_div,
	output logic                ce_pix,      // one cycle in act_ce_div
	output logic                hsync,
	output logic                vsync,
	output logic                hblank,
	output logic                vblank,
	output logic                active,
	output logic                frame_end,   // ce cycle of last pixel in frame
	output raster_pkg::coord_t  line,
	output raster_pkg::frame_t  frame_count
);
	import raster_pkg::*;

	ce_div_t ce_cnt;
	coord_t  h_cnt, v_cnt;
	coord_t  h_fp_end, h_sync_end, h_last;
	coord_t  v_fp_end, v_sync_end, v_last;
	logic    h_wrap, v_wrap;
	logic    v_act_last;                     // last active line

	//////////////////////////////////////////////////////////////////////
	// pixel clock enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst)
			ce_cnt <= '0;
		else if (ce_cnt >= act_ce_div - 4'd1) // >= so a smaller divisor still wraps
			ce_cnt <= '0;
		else
			ce_cnt <= ce_cnt + 4'd1;
	end

	assign ce_pix = (ce_cnt == '0);

	//////////////////////////////////////////////////////////////////////
	// segment boundaries from the modeline
	//////////////////////////////////////////////////////////////////////

	assign h_fp_end   = act_h + coord_t'(act_hfp);
	assign h_sync_end = h_fp_end + coord_t'(act_hs);
	assign h_last     = h_sync_end + coord_t'(act_hbp) - 12'd1;

	assign v_fp_end   = act_v + coord_t'(act_vfp);
	assign v_sync_end = v_fp_end + coord_t'(act_vs);
	assign v_last     = v_sync_end + coord_t'(act_vbp) - 12'd1;

	assign h_wrap     = (h_cnt >= h_last);
	assign v_wrap     = (v_cnt >= v_last);
	assign v_act_last = (v_cnt == act_v - 12'd1);

	//////////////////////////////////////////////////////////////////////
	// position counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (ce_pix) begin
			if (h_wrap) begin
				h_cnt <= '0;
				if (v_wrap)
					v_cnt <= '0;       // new frame
				else
					v_cnt <= v_cnt + 12'd1;
			end else begin
				h_cnt <= h_cnt + 12'd1;
			end
		end
	end

	// counts at vblank entry, so it steps right after the last active pixel
	always_ff @(posedge clk_sys) begin
		if (rst)
			frame_count <= '0;
		else if (ce_pix && h_wrap && v_act_last)
			frame_count <= frame_count + 16'd1;
	end

	// decode, all from counters
	assign hblank    = (h_cnt >= act_h);
	assign vblank    = (v_cnt >= act_v);
	assign hsync     = (h_cnt >= h_fp_end) && (h_cnt < h_sync_end);
	assign vsync     = (v_cnt >= v_fp_end) && (v_cnt < v_sync_end);
	assign active    = !hblank && !vblank;
	assign frame_end = ce_pix && h_wrap && v_wrap;
	assign line      = v_cnt;

endmodule

/* source/video_out.sv */
/* outputs lag the raster decode by one clock
   rgb is black outside the active area and on underrun; counter saturates */
`timescale 1ns/100ps

module video_out (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               ce_pix,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               hblank,
	input  logic               vblank,
	input  logic               active,
	input  logic               pix_ready,
	input  raster_pkg::pixel_t pix_data,
	output logic               pix_take,       // pops pix_data on this edge
	output logic               de,
	output logic               hs,
	output logic               vs,
	output logic               hb,
	output logic               vb,
	output logic               ce_out,
	output raster_pkg::pixel_t rgb,
	output raster_pkg::stat_t  underrun_count
);

	logic starved;                              // active pixel with nothing buffered

	assign pix_take = ce_pix && active && pix_ready;
	assign starved  = ce_pix && active && !pix_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ce_out <= 1'b0;
			de     <= 1'b0;
			hs     <= 1'b0;
			vs     <= 1'b0;
			hb     <= 1'b0;
			vb     <= 1'b0;
			rgb    <= '0;
		end else begin
			ce_out <= ce_pix;
			de     <= active;
			hs     <= hsync;
			vs     <= vsync;
			hb     <= hblank;
			vb     <= vblank;
			if (ce_pix) begin
				if (pix_take)
					rgb <= pix_data;
				else
					rgb <= '0;      // blanking or starved, black
			end
		end
	end

	// one count per starved pixel
	always_ff @(posedge clk_sys) begin
		if (rst)
			underrun_count <= '0;
		else if (starved && underrun_count != '1)
			underrun_count <= underrun_count + 16'd1;
	end

endmodule

/* tb/raster_core_chk.sv */
/* bound into every pixel_fetch instance
   all properties are disabled while rst is high */
`timescale 1ns/100ps

module raster_core_chk (
	input logic clk_sys,
	input logic rst,
	input logic push,
	input logic full,
	input logic empty,
	input logic pix_take,
	input logic pix_ready,
	input logic word_credit
);

	// reader sent a word without a credit
	no_push_full: assert property (@(posedge clk_sys) disable iff (rst)
		!(push && full))
		else $error("word pushed into a full buffer");

	// take only what is there
	take_ready: assert property (@(posedge clk_sys) disable iff (rst)
		pix_take |-> pix_ready)
		else $error("pix_take without pix_ready");

	no_credit_empty: assert property (@(posedge clk_sys) disable iff (rst)
		!(word_credit && empty))
		else $error("credit returned from an empty buffer");

endmodule

bind pixel_fetch raster_core_chk u_chk (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.push        (push),
	.full        (full),
	.empty       (empty),
	.pix_take    (pix_take),
	.pix_ready   (pix_ready),
	.word_credit (word_credit)
);

/* tb/raster_core_tb.sv */
/* default mode runs to its first vblank starved, then a 16x6 test mode is loaded
   the word source starts at a test mode vblank and always honors credits */
`timescale 1ns/100ps

module raster_core_tb;
	import raster_pkg::*;

	localparam int N_FRAMES   = 6;           // test mode frames checked with data
	localparam int DEF_HTOT   = int'(DEF_H) + int'(DEF_HFP) + int'(DEF_HS) + int'(DEF_HBP);
	localparam int DEF_VTOT   = int'(DEF_V) + int'(DEF_VFP) + int'(DEF_VS) + int'(DEF_VBP);
	localparam int T_HTOT     = 23;          // 16 + 2 + 3 + 2
	localparam int T_VTOT     = 10;          // 6 + 1 + 2 + 1
	localparam int MAX_CYCLES = DEF_HTOT * DEF_VTOT * int'(DEF_CE_DIV)
	                          + (N_FRAMES + 3) * T_HTOT * T_VTOT * 2 + 2000;

	logic     clk_sys = 1'b0;
	logic     rst, mode_load, word_valid;
	coord_t   mode_h, mode_v, line, prev_line;
	porch_t   mode_hfp, mode_hs, mode_hbp, mode_vfp, mode_vs, mode_vbp;
	ce_div_t  mode_ce_div;
	fb_word_t word_data;
	logic     mode_busy, word_credit, ce_out, hs, vs, hb, vb, de;
	pixel_t   rgb;
	frame_t   frame_count;
	stat_t    underrun_count, under_base;

	pixel_t      pix_q[$];                   // model, pixels sent and not yet shown
	logic [31:0] lcg_state = 32'h640f;
	logic        reader_en = 1'b0, check_data = 1'b0;
	logic        prev_de = 1'b0, prev_hs = 1'b0, prev_vs = 1'b0, prev_vb = 1'b0;
	logic        prev_busy = 1'b0, prev_hb = 1'b0;
	int credits = FIFO_DEPTH;
	int sent, returned, pix_checked, value_errs, event_errs, cycles;
	int de_cnt, hs_cnt, vs_cnt, line_cnt, hact_cnt, frames_seen;
	int exp_h = int'(DEF_H), exp_hs = int'(DEF_HS), exp_vs = int'(DEF_VS);
	int exp_v = int'(DEF_V), exp_htot = DEF_HTOT;

	raster_core_top u_dut (.*);

	always #2 clk_sys = ~clk_sys;            // 4 ns

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %s got %h exp %h", sig, got, exp);
		value_errs++;
	endtask

	task automatic event_error(input string what);
		$display("error: %s", what);
		event_errs++;
	endtask

	task automatic set_mode(input coord_t h, input porch_t hfp, input porch_t hsw,
		input porch_t hbp, input coord_t v, input porch_t vfp, input porch_t vsw,
		input porch_t vbp, input ce_div_t div);
		mode_h      = h;
		mode_hfp    = hfp;
		mode_hs     = hsw;
		mode_hbp    = hbp;
		mode_v      = v;
		mode_vfp    = vfp;
		mode_vs     = vsw;
		mode_vbp    = vbp;
		mode_ce_div = div;
	endtask

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run did not end within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word source, spends one credit per word, random gaps
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		int          k;
		logic [31:0] gap;
		#1;
		word_valid = 1'b0;
		gap = next_rand();
		if (reader_en && credits > 0 && gap[17:16] != 2'b00) begin
			word_valid = 1'b1;
			word_data  = {next_rand(), next_rand(), next_rand()};
			for (k = 0; k < PIX_PER_WORD; k++)
				pix_q.push_back(word_data[k*PIX_W +: PIX_W]); // pixel 0 first
			credits = credits - 1;
			sent    = sent + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output monitor, sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		pixel_t exp_pix;
		if (word_credit) begin
			credits  = credits + 1;
			returned = returned + 1;
		end
		if (credits < 0 || credits > FIFO_DEPTH)
			event_error("reader credit count left the range 0 to FIFO_DEPTH");

		if (de && ce_out && check_data) begin
			if (pix_q.size() == 0) begin
				event_error("pixel shown with nothing left in the model queue");
			end else begin
				exp_pix = pix_q.pop_front();
				if (rgb != exp_pix)
					value_error("rgb", 32'(rgb), 32'(exp_pix));
			end
			if (underrun_count != under_base)
				value_error("underrun_count", 32'(underrun_count), 32'(under_base));
			pix_checked++;
		end
		if (de && !check_data && rgb != '0)  // starved, must stay black
			value_error("rgb", 32'(rgb), 32'h0);

		if (ce_out && de) de_cnt++;
		if (ce_out && hs) hs_cnt++;
		if (ce_out && vs) vs_cnt++;          // pixels, so lines times h total
		if (ce_out && !hb) hact_cnt++;       // hb low part of every line
		if (prev_de && !de) begin
			if (de_cnt != exp_h)
				value_error("de pixels per line", de_cnt, exp_h);
			de_cnt = 0;
			line_cnt++;
		end
		if (!prev_hb && hb) begin
			if (hact_cnt != exp_h)
				value_error("hb low pixels per line", hact_cnt, exp_h);
			hact_cnt = 0;
		end
		if (prev_hs && !hs) begin
			if (hs_cnt != exp_hs)
				value_error("hs width", hs_cnt, exp_hs);
			hs_cnt = 0;
		end
		if (prev_vs && !vs) begin
			if (vs_cnt != exp_vs * exp_htot)
				value_error("vs width in pixels", vs_cnt, exp_vs * exp_htot);
			vs_cnt = 0;
		end
		if (!prev_vb && vb) begin
			if (line_cnt != exp_v)
				value_error("de lines per frame", line_cnt, exp_v);
			line_cnt = 0;
			frames_seen++;                   // frame_count stepped one clock earlier
			if (frame_count != frame_t'(frames_seen))
				value_error("frame_count", 32'(frame_count), frames_seen);
		end
		// swap lands right after the last line of the old frame
		if (prev_busy && !mode_busy) begin
			if (int'(prev_line) != DEF_VTOT - 1)
				value_error("line before swap", 32'(prev_line), DEF_VTOT - 1);
			if (line != '0)
				value_error("line after swap", 32'(line), 32'h0);
			exp_h    = 16;
			exp_hs   = 3;
			exp_vs   = 2;
			exp_v    = 6;
			exp_htot = T_HTOT;
		end
		prev_de   = de;
		prev_hs   = hs;
		prev_vs   = vs;
		prev_vb   = vb;
		prev_hb   = hb;
		prev_busy = mode_busy;
		prev_line = line;
	end

	//////////////////////////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst        = 1'b1;
		mode_load  = 1'b0;
		word_valid = 1'b0;
		word_data  = '0;
		set_mode(DEF_H, DEF_HFP, DEF_HS, DEF_HBP, DEF_V, DEF_VFP, DEF_VS, DEF_VBP, DEF_CE_DIV);
		repeat (3) @(posedge clk_sys);
		#1 rst = 1'b0;

		// whole first active area starved
		while (frame_count != 16'd1) @(negedge clk_sys);
		if (int'(underrun_count) != int'(DEF_H) * int'(DEF_V))
			value_error("underrun_count", 32'(underrun_count), int'(DEF_H) * int'(DEF_V));

		@(posedge clk_sys);
		#1;
		set_mode(12'd16, 8'd2, 8'd3, 8'd2, 12'd6, 8'd1, 8'd2, 8'd1, 4'd2);
		mode_load = 1'b1;
		@(posedge clk_sys);
		#1 mode_load = 1'b0;
		@(negedge clk_sys);
		if (!mode_busy)
			event_error("mode_busy did not rise after mode_load");
		while (mode_busy) @(negedge clk_sys);

		// start the source at a fresh test mode vblank
		while (vb) @(negedge clk_sys);
		while (!vb) @(negedge clk_sys);
		under_base = underrun_count;
		check_data = 1'b1;
		reader_en  = 1'b1;
		repeat (N_FRAMES) begin
			while (vb) @(negedge clk_sys);
			while (!vb) @(negedge clk_sys);
		end
		reader_en = 1'b0;
		repeat (4) @(negedge clk_sys);

		if (pix_checked != N_FRAMES * 96)
			value_error("pixels checked", pix_checked, N_FRAMES * 96);
		if (sent - returned != (pix_q.size() + PIX_PER_WORD - 1) / PIX_PER_WORD)
			value_error("words buffered", sent - returned, (pix_q.size() + 3) / PIX_PER_WORD);
		if (sent - returned > FIFO_DEPTH)
			event_error("more words outstanding than the buffer holds");

		$display("errors: %0d value, %0d other; %0d pixels checked, %0d words sent",
			value_errs, event_errs, pix_checked, sent);
		if (value_errs == 0 && event_errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
